/* Bender.yml */
package:
  name: i2c_standby

sources:
  - common/i2c_standby_pkg.sv
  - verilog/tti_queue.sv
  - flow_standby/flow_standby_i2c.sv
  - verilog/i2c_standby_top.sv
  - target: simulation
    files:
      - verification/tb_i2c_standby.sv

/* all.f */
common/i2c_standby_pkg.sv
verilog/tti_queue.sv
flow_standby/flow_standby_i2c.sv
verilog/i2c_standby_top.sv
verification/tb_i2c_standby.sv

/* common/i2c_standby_pkg.sv */
// Shared constants, acquisition tags and TTI descriptor types of the I2C standby path
`default_nettype none

package i2c_standby_pkg;

  // One acquisition word is a data byte plus its tag
  localparam int AcqWidth = 11;
  localparam int AcqIdWidth = AcqWidth - 8;

  // Entries in each TTI queue
  localparam int QueueDepth = 4;

  // TX and RX queue word width
  localparam int DataWidth = 32;

  // Byte counts in descriptors and in the transfer counter
  localparam int ByteCountWidth = 16;

  // Tag that the bus engine attaches to each acquired byte
  typedef enum logic [AcqIdWidth-1:0] {
    AcqData    = 3'b000,
    AcqStart   = 3'b001,
    AcqStop    = 3'b010,
    AcqRestart = 3'b011,
    AcqNack    = 3'b100
  } acq_id_e;

  typedef struct packed {
    acq_id_e    id;
    logic [7:0] data;
  } acq_word_t;

  // Command descriptor, only the read length is used here
  typedef struct packed {
    logic [ByteCountWidth-1:0] data_length;
    logic [15:0]               rsvd;
  } cmd_desc_t;

  // Response descriptor, written once per write transfer
  typedef struct packed {
    logic [3:0]                err_status;
    logic [3:0]                rsvd;
    logic [7:0]                tid;
    logic [ByteCountWidth-1:0] data_length;
  } resp_desc_t;

endpackage

`default_nettype wire

/* flow_standby/flow_standby_i2c.sv */
// Standby I2C flow that bridges the acquisition stream to the TTI queues
`default_nettype none

module flow_standby_i2c (
  input  wire                                   clk_i,
  input  wire                                   rst_ni,
  input  wire                                   acq_valid_i,
  input  wire i2c_standby_pkg::acq_word_t       acq_word_i,
  input  wire                                   rnw_i,
  output logic [2:0]                            acq_depth_o,
  output logic [7:0]                            tx_byte_o,
  output logic                                  tx_byte_valid_o,
  input  wire                                   tx_byte_ready_i,
  input  wire i2c_standby_pkg::cmd_desc_t       cmd_desc_i,
  input  wire                                   cmd_valid_i,
  output logic                                  cmd_ready_o,
  input  wire [i2c_standby_pkg::DataWidth-1:0]  tx_data_i,
  input  wire                                   tx_valid_i,
  output logic                                  tx_ready_o,
  output logic [i2c_standby_pkg::DataWidth-1:0] rx_data_o,
  output logic                                  rx_valid_o,
  input  wire                                   rx_ready_i,
  output i2c_standby_pkg::resp_desc_t           resp_desc_o,
  output logic                                  resp_valid_o,
  input  wire                                   resp_ready_i,
  output logic                                  err_o
);

  typedef enum logic [3:0] {
    StAwaitStart,
    StReceiveByte,
    StPushWord,
    StPushResp,
    StPopCmd,
    StPopWord,
    StSendByte,
    StSwitchByte,
    StAwaitStop,
    StError
  } state_e;

  state_e                     state_q;
  state_e                     state_d;
  logic                       acq_valid_q;
  i2c_standby_pkg::acq_word_t acq_word_q;
  logic                       rnw_q;

  // Event flags decoded from the registered acquisition word
  logic start_det;
  logic stop_det;
  logic restart_det;
  logic data_det;
  logic nack_det;
  logic end_det;

  logic [3:0][7:0]                              word_buf_q;
  logic [3:0][7:0]                              tx_word_q;
  logic [i2c_standby_pkg::ByteCountWidth-1:0]   byte_cnt_q;
  logic [i2c_standby_pkg::ByteCountWidth-1:0]   read_len_q;
  logic                                         xfer_active_q;
  // A restart that ended a transfer also opens the next one
  logic                                         resume_q;
  logic                                         resume_rnw_q;

  logic begin_xfer;
  logic begin_rnw;
  logic enter_xfer;
  logic end_xfer;
  logic store_byte;
  logic push_byte;
  logic cnt_clear;
  logic xfer_read;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acq_valid_q <= 1'b0;
      rnw_q       <= 1'b0;
      state_q     <= StAwaitStart;
    end else begin
      acq_valid_q <= acq_valid_i;
      rnw_q       <= rnw_i;
      state_q     <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    acq_word_q <= acq_word_i;
  end

  assign start_det   = acq_valid_q && (acq_word_q.id == i2c_standby_pkg::AcqStart);
  assign stop_det    = acq_valid_q && (acq_word_q.id == i2c_standby_pkg::AcqStop);
  assign restart_det = acq_valid_q && (acq_word_q.id == i2c_standby_pkg::AcqRestart);
  assign data_det    = acq_valid_q && (acq_word_q.id == i2c_standby_pkg::AcqData);
  assign nack_det    = acq_valid_q && (acq_word_q.id == i2c_standby_pkg::AcqNack);
  assign end_det     = stop_det || restart_det;

  assign begin_xfer = start_det || restart_det || resume_q;
  assign begin_rnw  = (start_det || restart_det) ? rnw_q : resume_rnw_q;

  always_comb begin
    state_d         = state_q;
    enter_xfer      = 1'b0;
    end_xfer        = 1'b0;
    store_byte      = 1'b0;
    cmd_ready_o     = 1'b0;
    tx_ready_o      = 1'b0;
    rx_valid_o      = 1'b0;
    resp_valid_o    = 1'b0;
    tx_byte_valid_o = 1'b0;
    err_o           = 1'b0;
    xfer_read       = 1'b0;

    unique case (state_q)
      StAwaitStart: begin
        if (begin_xfer) begin
          enter_xfer = 1'b1;
          state_d = begin_rnw ? StPopCmd : StReceiveByte;
        end
      end
      StReceiveByte: begin
        if (end_det) begin
          end_xfer = 1'b1;
          state_d = (byte_cnt_q[1:0] != 2'd0) ? StPushWord : StPushResp;
        end else if (data_det) begin
          store_byte = 1'b1;
          if (byte_cnt_q[1:0] == 2'd3) begin
            state_d = StPushWord;
          end
        end else if (acq_valid_q) begin
          state_d = StError;
        end
      end
      StPushWord: begin
        rx_valid_o = 1'b1;
        // The bus cannot be held, so a new event with a stalled queue is fatal
        if (!rx_ready_i) begin
          if (acq_valid_q) begin
            state_d = StError;
          end
        end else if (!xfer_active_q) begin
          state_d = StPushResp;
        end else if (end_det) begin
          end_xfer = 1'b1;
          state_d = StPushResp;
        end else if (data_det || !acq_valid_q) begin
          store_byte = data_det;
          state_d = StReceiveByte;
        end else begin
          state_d = StError;
        end
      end
      StPushResp: begin
        resp_valid_o = 1'b1;
        if (resp_ready_i) begin
          state_d = StAwaitStart;
          if (begin_xfer) begin
            enter_xfer = 1'b1;
            state_d = begin_rnw ? StPopCmd : StReceiveByte;
          end
        end else if (acq_valid_q) begin
          state_d = StError;
        end
      end
      StPopCmd: begin
        xfer_read = 1'b1;
        cmd_ready_o = !(nack_det || end_det);
        if (cmd_valid_i) begin
          state_d = (cmd_desc_i.data_length == '0) ? StError : StPopWord;
        end
      end
      StPopWord: begin
        xfer_read = 1'b1;
        tx_ready_o = !(nack_det || end_det);
        if (tx_valid_i) begin
          state_d = StSendByte;
        end
      end
      StSendByte: begin
        xfer_read = 1'b1;
        tx_byte_valid_o = 1'b1;
        if (tx_byte_ready_i) begin
          state_d = (byte_cnt_q + 1'b1 == read_len_q) ? StAwaitStop : StSwitchByte;
        end
      end
      StSwitchByte: begin
        xfer_read = 1'b1;
        // Lane 3 was just sent, so the next byte needs a fresh word
        state_d = (byte_cnt_q[1:0] == 2'd3) ? StPopWord : StSendByte;
      end
      StAwaitStop: begin
        xfer_read = 1'b1;
      end
      StError: begin
        err_o = 1'b1;
      end
      default: begin
        state_d = StError;
      end
    endcase

    // Common to all read states
    if (xfer_read) begin
      if (nack_det) begin
        state_d = StError;
      end else if (end_det) begin
        end_xfer = 1'b1;
        state_d = StAwaitStart;
      end
    end
  end

  assign push_byte = store_byte || (state_q == StSwitchByte);
  assign cnt_clear = (state_q == StAwaitStart) || (resp_valid_o && resp_ready_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      byte_cnt_q    <= '0;
      read_len_q    <= '0;
      xfer_active_q <= 1'b0;
      resume_q      <= 1'b0;
      resume_rnw_q  <= 1'b0;
    end else begin
      if (cnt_clear) begin
        byte_cnt_q <= '0;
      end else if (push_byte) begin
        byte_cnt_q <= byte_cnt_q + 1'b1;
      end
      if (cmd_valid_i && cmd_ready_o) begin
        read_len_q <= cmd_desc_i.data_length;
      end
      if (enter_xfer) begin
        xfer_active_q <= 1'b1;
      end else if (end_xfer) begin
        xfer_active_q <= 1'b0;
      end
      if (end_xfer && restart_det) begin
        resume_q     <= 1'b1;
        resume_rnw_q <= rnw_q;
      end else if (enter_xfer) begin
        resume_q <= 1'b0;
      end
    end
  end

  // Word buffer starts empty, so unused upper lanes of a short word stay zero
  always_ff @(posedge clk_i) begin
    if (cnt_clear || (rx_valid_o && rx_ready_i)) begin
      word_buf_q <= '0;
    end
    if (store_byte) begin
      word_buf_q[byte_cnt_q[1:0]] <= acq_word_q.data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (tx_valid_i && tx_ready_o) begin
      tx_word_q <= tx_data_i;
    end
  end

  assign rx_data_o = word_buf_q;
  assign tx_byte_o = tx_word_q[byte_cnt_q[1:0]];

  // Buffer occupancy, a full word waiting in the push state counts as four
  assign acq_depth_o = xfer_read ? 3'd0 :
                       (rx_valid_o && (byte_cnt_q[1:0] == 2'd0)) ? 3'd4 :
                       {1'b0, byte_cnt_q[1:0]};

  assign resp_desc_o = '{err_status: '0, rsvd: '0, tid: '0, data_length: byte_cnt_q};

endmodule

`default_nettype wire

/* verification/standby_input.txt */
# W bytes end (0 stop, 1 restart) | R length words | Z zero-length read
# N mode bytes (mode 0 write nack, 1 read nack, 2 RX queue stall)
W 8 0
W 5 0
R 6 2
Z
N 0 3
N 1 0
N 2 21
W 6 1
W 4 1
W 3 0

/* verification/tb_i2c_standby.sv */
// Testbench for the standby I2C path, driven by operation records from a data file
`default_nettype none

module tb_i2c_standby;

  logic                        clk_i;
  logic                        rst_ni;
  logic                        acq_valid_i;
  i2c_standby_pkg::acq_word_t  acq_word_i;
  logic                        rnw_i;
  logic [2:0]                  acq_depth_o;
  logic [7:0]                  tx_byte_o;
  logic                        tx_byte_valid_o;
  logic                        tx_byte_ready_i;
  logic                        cmd_valid_i;
  logic                        cmd_ready_o;
  i2c_standby_pkg::cmd_desc_t  cmd_desc_i;
  logic                        tx_valid_i;
  logic                        tx_ready_o;
  logic [31:0]                 tx_data_i;
  logic                        rx_valid_o;
  logic                        rx_ready_i;
  logic [31:0]                 rx_data_o;
  logic                        resp_valid_o;
  logic                        resp_ready_i;
  i2c_standby_pkg::resp_desc_t resp_desc_o;
  logic                        err_o;

  logic [31:0] rng_state;
  logic [31:0] exp_rx[$];
  logic [31:0] exp_resp[$];
  logic [7:0]  exp_tx[$];
  logic [7:0]  rec_op[$];
  int          rec_a[$];
  int          rec_b[$];
  int          cycle_cnt = 0;
  int          cycle_limit = 1000000;
  bit          xfer_open;

  i2c_standby_top dut0 (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .acq_valid_i    (acq_valid_i),
    .acq_word_i     (acq_word_i),
    .rnw_i          (rnw_i),
    .acq_depth_o    (acq_depth_o),
    .tx_byte_o      (tx_byte_o),
    .tx_byte_valid_o(tx_byte_valid_o),
    .tx_byte_ready_i(tx_byte_ready_i),
    .cmd_valid_i    (cmd_valid_i),
    .cmd_ready_o    (cmd_ready_o),
    .cmd_desc_i     (cmd_desc_i),
    .tx_valid_i     (tx_valid_i),
    .tx_ready_o     (tx_ready_o),
    .tx_data_i      (tx_data_i),
    .rx_valid_o     (rx_valid_o),
    .rx_ready_i     (rx_ready_i),
    .rx_data_o      (rx_data_o),
    .resp_valid_o   (resp_valid_o),
    .resp_ready_i   (resp_ready_i),
    .resp_desc_o    (resp_desc_o),
    .err_o          (err_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "Run stopped");
  endtask

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected) begin
      $display("MISMATCH time=%0t signal=%s actual=%h expected=%h",
               $time, name, actual, expected);
      abort_run("Value check failed");
    end
  endtask

  // One bus event, then three idle cycles as a real byte time would give
  task automatic send_acq(input i2c_standby_pkg::acq_id_e tag, input logic [7:0] data,
                          input logic rnw);
    @(negedge clk_i);
    acq_valid_i = 1'b1;
    acq_word_i.id = tag;
    acq_word_i.data = data;
    rnw_i = rnw;
    @(negedge clk_i);
    acq_valid_i = 1'b0;
    repeat (2) @(negedge clk_i);
  endtask

  task automatic push_sw(input bit to_cmd, input logic [31:0] value);
    @(negedge clk_i);
    if (to_cmd) begin
      cmd_valid_i = 1'b1;
      cmd_desc_i = value;
    end else begin
      tx_valid_i = 1'b1;
      tx_data_i = value;
    end
    do begin
      @(posedge clk_i);
    end while (!(to_cmd ? cmd_ready_o : tx_ready_o));
    @(negedge clk_i);
    cmd_valid_i = 1'b0;
    tx_valid_i = 1'b0;
  endtask

  task automatic wait_drained();
    while (exp_rx.size() != 0 || exp_resp.size() != 0 || exp_tx.size() != 0) begin
      @(negedge clk_i);
    end
  endtask

  task automatic apply_reset();
    @(negedge clk_i);
    rst_ni = 1'b0;
    acq_valid_i = 1'b0;
    cmd_valid_i = 1'b0;
    tx_valid_i = 1'b0;
    rx_ready_i = 1'b1;
    resp_ready_i = 1'b1;
    tx_byte_ready_i = 1'b1;
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    xfer_open = 1'b0;
  endtask

  // Random data bytes, least significant lane first in each word
  task automatic send_write_bytes(input int n, input bit expect_words,
                                  output logic [31:0] tail);
    logic [31:0] word;
    word = '0;
    for (int i = 0; i < n; i++) begin
      rng_state = xorshift(rng_state);
      word[8*(i%4) +: 8] = rng_state[7:0];
      if (i % 4 == 3) begin
        if (expect_words) begin
          exp_rx.push_back(word);
        end
        word = '0;
      end
      send_acq(i2c_standby_pkg::AcqData, rng_state[7:0], 1'b0);
      // Only the bytes of the unfinished word remain in the buffer
      if (expect_words) begin
        check("acq_depth_o", acq_depth_o, (i + 1) % 4);
      end
    end
    tail = word;
  endtask

  task automatic run_write(input int n, input bit use_restart);
    logic [31:0] tail;
    if (!xfer_open) begin
      send_acq(i2c_standby_pkg::AcqStart, 8'h00, 1'b0);
    end
    send_write_bytes(n, 1'b1, tail);
    if (n % 4 != 0) begin
      exp_rx.push_back(tail);
    end
    exp_resp.push_back({16'h0000, n[15:0]});
    if (use_restart) begin
      send_acq(i2c_standby_pkg::AcqRestart, 8'h00, 1'b0);
    end else begin
      send_acq(i2c_standby_pkg::AcqStop, 8'h00, 1'b0);
      wait_drained();
    end
    xfer_open = use_restart;
  endtask

  task automatic run_read(input int len, input int words);
    logic [31:0] w;
    for (int k = 0; k < words; k++) begin
      rng_state = xorshift(rng_state);
      w = rng_state;
      for (int j = 0; j < 4; j++) begin
        if (4 * k + j < len) begin
          exp_tx.push_back(w[8*j +: 8]);
        end
      end
      push_sw(1'b0, w);
    end
    push_sw(1'b1, {len[15:0], 16'h0000});
    send_acq(i2c_standby_pkg::AcqStart, 8'h00, 1'b1);
    wait_drained();
    // The word buffer stays empty on reads
    check("acq_depth_o", acq_depth_o, 3'd0);
    // Any byte offered here has no expected value and fails in the monitor
    repeat (8) @(negedge clk_i);
    send_acq(i2c_standby_pkg::AcqStop, 8'h00, 1'b1);
    check("err_o", err_o, 1'b0);
  endtask

  task automatic await_error();
    while (!err_o) begin
      @(negedge clk_i);
    end
    repeat (8) begin
      @(negedge clk_i);
      check("err_o", err_o, 1'b1);
    end
    wait_drained();
    apply_reset();
  endtask

  task automatic run_error(input int mode, input int n);
    logic [31:0] tail;
    if (mode == 0) begin
      send_acq(i2c_standby_pkg::AcqStart, 8'h00, 1'b0);
      send_write_bytes(n, 1'b1, tail);
      send_acq(i2c_standby_pkg::AcqNack, 8'h00, 1'b0);
    end else if (mode == 1) begin
      tx_byte_ready_i = 1'b0;
      rng_state = xorshift(rng_state);
      push_sw(1'b0, rng_state);
      push_sw(1'b1, {16'd4, 16'h0000});
      send_acq(i2c_standby_pkg::AcqStart, 8'h00, 1'b1);
      send_acq(i2c_standby_pkg::AcqNack, 8'h00, 1'b1);
    end else begin
      // RX queue fills and stays full, so a later byte cannot be stored
      rx_ready_i = 1'b0;
      send_acq(i2c_standby_pkg::AcqStart, 8'h00, 1'b0);
      send_write_bytes(n, 1'b0, tail);
    end
    await_error();
  endtask

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      abort_run($sformatf("Timeout after %0d cycles, the DUT stopped making progress",
                          cycle_cnt));
    end
    if (rst_ni) begin
      if (rx_valid_o && rx_ready_i) begin
        if (exp_rx.size() == 0) begin
          abort_run("An RX word appeared that no transfer should produce");
        end else begin
          check("rx_data_o", rx_data_o, exp_rx.pop_front());
        end
      end
      if (resp_valid_o && resp_ready_i) begin
        if (exp_resp.size() == 0) begin
          abort_run("A response appeared that no transfer should produce");
        end else begin
          check("resp_desc_o", resp_desc_o, exp_resp.pop_front());
        end
      end
      if (tx_byte_valid_o && tx_byte_ready_i) begin
        if (exp_tx.size() == 0) begin
          abort_run("A TX byte was offered beyond the read length");
        end else begin
          check("tx_byte_o", tx_byte_o, exp_tx.pop_front());
        end
      end
    end
  end

  initial begin
    int          fd;
    int          code;
    int          a;
    int          b;
    int          total;
    string       line;
    logic [7:0]  op;
    rst_ni = 1'b1;
    acq_valid_i = 1'b0;
    acq_word_i = '0;
    rnw_i = 1'b0;
    tx_byte_ready_i = 1'b1;
    cmd_valid_i = 1'b0;
    cmd_desc_i = '0;
    tx_valid_i = 1'b0;
    tx_data_i = '0;
    rx_ready_i = 1'b1;
    resp_ready_i = 1'b1;
    xfer_open = 1'b0;
    rng_state = 32'ha6a16b41;
    total = 0;

    fd = $fopen("verification/standby_input.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open the stimulus file verification/standby_input.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      code = $fgets(line, fd);
      if (code > 0 && line[0] != "#" && line[0] != "\n") begin
        a = 0;
        b = 0;
        code = $sscanf(line, "%c %d %d", op, a, b);
        rec_op.push_back(op);
        rec_a.push_back(a);
        rec_b.push_back(b);
        total += (op == "N") ? b + 1 : ((op == "Z") ? 1 : a);
      end
    end
    $fclose(fd);
    cycle_limit = 64 * total + 200;

    apply_reset();
    for (int r = 0; r < rec_op.size(); r++) begin
      case (rec_op[r])
        "W": run_write(rec_a[r], rec_b[r] != 0);
        "R": run_read(rec_a[r], rec_b[r]);
        "N": run_error(rec_a[r], rec_b[r]);
        "Z": begin
          push_sw(1'b1, 32'h0000_0000);
          send_acq(i2c_standby_pkg::AcqStart, 8'h00, 1'b1);
          await_error();
        end
        default: abort_run("Unknown opcode in the stimulus file");
      endcase
    end
    wait_drained();
    check("err_o", err_o, 1'b0);
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/i2c_standby_top.sv */
// Standby I2C top level with the flow block and its four TTI queues
`default_nettype none

module i2c_standby_top (
  input  wire                                   clk_i,
  input  wire                                   rst_ni,
  input  wire                                   acq_valid_i,
  input  wire i2c_standby_pkg::acq_word_t       acq_word_i,
  input  wire                                   rnw_i,
  output logic [2:0]                            acq_depth_o,
  output logic [7:0]                            tx_byte_o,
  output logic                                  tx_byte_valid_o,
  input  wire                                   tx_byte_ready_i,
  input  wire                                   cmd_valid_i,
  output logic                                  cmd_ready_o,
  input  wire i2c_standby_pkg::cmd_desc_t       cmd_desc_i,
  input  wire                                   tx_valid_i,
  output logic                                  tx_ready_o,
  input  wire [i2c_standby_pkg::DataWidth-1:0]  tx_data_i,
  output logic                                  rx_valid_o,
  input  wire                                   rx_ready_i,
  output logic [i2c_standby_pkg::DataWidth-1:0] rx_data_o,
  output logic                                  resp_valid_o,
  input  wire                                   resp_ready_i,
  output i2c_standby_pkg::resp_desc_t           resp_desc_o,
  output logic                                  err_o
);

  // Queue side of the flow block
  i2c_standby_pkg::cmd_desc_t           cmd_q_desc;
  logic                                 cmd_q_valid;
  logic                                 cmd_q_ready;
  logic [i2c_standby_pkg::DataWidth-1:0] tx_q_data;
  logic                                 tx_q_valid;
  logic                                 tx_q_ready;
  logic [i2c_standby_pkg::DataWidth-1:0] rx_q_data;
  logic                                 rx_q_valid;
  logic                                 rx_q_ready;
  i2c_standby_pkg::resp_desc_t          resp_q_desc;
  logic                                 resp_q_valid;
  logic                                 resp_q_ready;

  flow_standby_i2c flow0 (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .acq_valid_i    (acq_valid_i),
    .acq_word_i     (acq_word_i),
    .rnw_i          (rnw_i),
    .acq_depth_o    (acq_depth_o),
    .tx_byte_o      (tx_byte_o),
    .tx_byte_valid_o(tx_byte_valid_o),
    .tx_byte_ready_i(tx_byte_ready_i),
    .cmd_desc_i     (cmd_q_desc),
    .cmd_valid_i    (cmd_q_valid),
    .cmd_ready_o    (cmd_q_ready),
    .tx_data_i      (tx_q_data),
    .tx_valid_i     (tx_q_valid),
    .tx_ready_o     (tx_q_ready),
    .rx_data_o      (rx_q_data),
    .rx_valid_o     (rx_q_valid),
    .rx_ready_i     (rx_q_ready),
    .resp_desc_o    (resp_q_desc),
    .resp_valid_o   (resp_q_valid),
    .resp_ready_i   (resp_q_ready),
    .err_o          (err_o)
  );

  tti_queue #(
    .Width($bits(i2c_standby_pkg::cmd_desc_t)),
    .Depth(i2c_standby_pkg::QueueDepth)
  ) cmd_queue (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .wvalid_i(cmd_valid_i),
    .wready_o(cmd_ready_o),
    .wdata_i (cmd_desc_i),
    .rvalid_o(cmd_q_valid),
    .rready_i(cmd_q_ready),
    .rdata_o (cmd_q_desc)
  );

  tti_queue #(
    .Width(i2c_standby_pkg::DataWidth),
    .Depth(i2c_standby_pkg::QueueDepth)
  ) tx_queue (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .wvalid_i(tx_valid_i),
    .wready_o(tx_ready_o),
    .wdata_i (tx_data_i),
    .rvalid_o(tx_q_valid),
    .rready_i(tx_q_ready),
    .rdata_o (tx_q_data)
  );

  tti_queue #(
    .Width(i2c_standby_pkg::DataWidth),
    .Depth(i2c_standby_pkg::QueueDepth)
  ) rx_queue (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .wvalid_i(rx_q_valid),
    .wready_o(rx_q_ready),
    .wdata_i (rx_q_data),
    .rvalid_o(rx_valid_o),
    .rready_i(rx_ready_i),
    .rdata_o (rx_data_o)
  );

  tti_queue #(
    .Width($bits(i2c_standby_pkg::resp_desc_t)),
    .Depth(i2c_standby_pkg::QueueDepth)
  ) resp_queue (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .wvalid_i(resp_q_valid),
    .wready_o(resp_q_ready),
    .wdata_i (resp_q_desc),
    .rvalid_o(resp_valid_o),
    .rready_i(resp_ready_i),
    .rdata_o (resp_desc_o)
  );

endmodule

`default_nettype wire

/* verilog/tti_queue.sv */
// Synchronous valid/ready FIFO standing in for one TTI queue
`default_nettype none

module tti_queue #(
  parameter int Width = 32,
  parameter int Depth = 4
) (
  input  wire              clk_i,
  input  wire              rst_ni,
  input  wire              wvalid_i,
  output logic             wready_o,
  input  wire [Width-1:0]  wdata_i,
  output logic             rvalid_o,
  input  wire              rready_i,
  output logic [Width-1:0] rdata_o
);

  localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntWidth = $clog2(Depth + 1);

  logic [Width-1:0]    mem_q[Depth];
  logic [PtrWidth-1:0] wptr_q;
  logic [PtrWidth-1:0] rptr_q;
  logic [CntWidth-1:0] count_q;
  logic                push;
  logic                pop;

  // Pointers wrap explicitly so any depth works
  function automatic logic [PtrWidth-1:0] next_ptr(input logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(Depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign rvalid_o = (count_q != '0);
  // A full queue still takes a word when one leaves in the same cycle
  assign wready_o = (count_q != CntWidth'(Depth)) || rready_i;
  assign push = wvalid_i && wready_o;
  assign pop = rvalid_o && rready_i;
  assign rdata_o = mem_q[rptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (push) begin
        wptr_q <= next_ptr(wptr_q);
      end
      if (pop) begin
        rptr_q <= next_ptr(rptr_q);
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wptr_q] <= wdata_i;
    end
  end

endmodule

`default_nettype wire
